/* flist.f */
hdl/cv_pkg.sv
hdl/key_matrix.sv
hdl/ctrl_port_mux.sv
hdl/cart_loader.sv
hdl/console_reset.sv
hdl/sram_arbiter.sv
hdl/cv_io_top.sv
tb/tb_cv_io_assertions.sv
tb/tb_cv_io.sv

/* Makefile */
TOP := tb_cv_io

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_cv_io.sv */
// Testbench for the ColecoVision input and memory glue with SRAM model
`default_nettype none

module tb_cv_io;
	timeunit 1ns;
	timeprecision 1ns;

	localparam logic [18:0] CART_AREA   = 19'h40000;   // Bit 18 set
	localparam int          TEST_CYCLES = 40 + 40 + 100 + 600 + 20 + 60;
	localparam int          LIMIT       = 2 * TEST_CYCLES;

	logic                clk_sys = 1'b0;
	logic                arst_n_i;
	logic [7:0]          key_code_i;
	logic                key_strobe_i;
	logic                key_pressed_i;
	logic [5:0]          joys_i;
	logic                joy_swap_i;
	cv_pkg::ctrl_sel_t   ctrl_sel_i;
	cv_pkg::ctrl_lines_t ctrl_o;
	logic                dl_active_i;
	logic                dl_wr_i;
	logic [7:0]          dl_index_i;
	logic [24:0]         dl_addr_i;
	logic [7:0]          dl_data_i;
	logic                reset_req_i;
	cv_pkg::ram_size_e   ram_size_i;
	logic                console_reset_o;
	logic                sg1000_o;
	logic                extram_o;
	logic [5:0]          cart_pages_o;
	cv_pkg::mem_req_t    cpu_req_i;
	cv_pkg::mem_req_t    cart_req_i;
	logic [7:0]          cpu_rdata_o;
	logic                cpu_rvalid_o;
	logic [7:0]          cart_rdata_o;
	logic                cart_rvalid_o;
	cv_pkg::sram_bus_t   sram_o;
	logic [7:0]          sram_rdata_i;

	logic [7:0]  sram_mem [0:524287];
	logic [7:0]  shadow [0:524287];
	logic [7:0]  exp_cpu[$];
	logic [7:0]  exp_cart[$];
	logic [31:0] rng = 32'd55;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          err_base = 0;
	int          cpu_seen;
	int          cart_seen;
	logic        m_sg = 1'b0;                 // Flag model
	logic        m_ext = 1'b0;
	logic [5:0]  m_pages = '0;
	cv_pkg::pad_t kbd_m;                      // Expected keyboard pad

	cv_io_top #(.CART_AW(18), .CPU_AW(15)) uut (.*);

	bind sram_arbiter tb_cv_io_assertions u_assertions (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .wr_req_i(wr_req_i), .cpu_req_i(cpu_req_i),
		.cart_req_i(cart_req_i), .sram_o(sram_o), .cpu_rvalid_o(cpu_rvalid_o),
		.cart_rvalid_o(cart_rvalid_o));

	always #5 clk_sys = ~clk_sys;

	// ------------------------------
	// SRAM model and timeout
	// ------------------------------
	always @(posedge clk_sys) begin
		cycles++;
		if (sram_o.en) begin
			if (sram_o.we)
				sram_mem[sram_o.addr] = sram_o.wdata;
			else
				sram_rdata_i <= sram_mem[sram_o.addr];
		end
		if (cycles > LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	// Read data comparison
	always @(negedge clk_sys) begin
		if (cpu_rvalid_o) begin
			cpu_seen = cycles;
			if (exp_cpu.size() == 0) begin
				$display("Unexpected CPU read data at time %0t", $time);
				errors++;
			end else
				check("cpu rdata", 32'(cpu_rdata_o), 32'(exp_cpu.pop_front()));
		end
		if (cart_rvalid_o) begin
			cart_seen = cycles;
			if (exp_cart.size() == 0) begin
				$display("Unexpected cart read data at time %0t", $time);
				errors++;
			end else
				check("cart rdata", 32'(cart_rdata_o), 32'(exp_cart.pop_front()));
		end
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%s finished with %0d errors", name, errors - err_base);
		err_base = errors;
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [7:0] fill_byte(input logic [18:0] a);
		return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]} ^ 8'h5A;
	endfunction

	function automatic logic [3:0] key_code(input int idx);
		case (idx)
			0: return 4'b0011;
			1: return 4'b1110;
			2: return 4'b1101;
			3: return 4'b0110;
			4: return 4'b0001;
			5: return 4'b1001;
			6: return 4'b0111;
			7: return 4'b1100;
			8: return 4'b1000;
			9: return 4'b1011;
			10: return 4'b1010;
			11: return 4'b0101;
			12: return 4'b0100;
			default: return 4'b0010;
		endcase
	endfunction

	// Reference for port lines from pads and selects
	function automatic cv_pkg::ctrl_lines_t expect_lines(input logic [5:0] joys,
		input logic swap, input cv_pkg::pad_t kbd, input cv_pkg::ctrl_sel_t sel);
		cv_pkg::ctrl_lines_t res;
		cv_pkg::pad_t        pads [2];
		logic [13:0]         keys;
		logic [3:0]          knib;
		logic [3:0]          dnib;
		logic                kp6;
		logic                dp6;
		logic [5:0]          phys;
		logic [5:0]          kdir;
		pads[0] = '0;
		pads[1] = '0;
		phys = ~joys;
		kdir = {kbd.up, kbd.down, kbd.left, kbd.right, kbd.fire1, kbd.fire2};
		for (int i = 0; i < 2; i++) begin
			{pads[i].up, pads[i].down, pads[i].left, pads[i].right, pads[i].fire1,
				pads[i].fire2} = ((i == 0) != swap) ? {phys[0], phys[1], phys[2], phys[3],
				phys[4], phys[5]} : kdir;
			pads[i][19:6] = kbd[19:6];
			keys = pads[i][19:6];
			knib = 4'b1111;
			dnib = 4'b1111;
			kp6  = 1'b1;
			dp6  = 1'b1;
			if (!sel.p5[i]) begin
				for (int k = 0; k < 14; k++)     // Lowest priority first, highest wins
					if (keys[k])
						knib = key_code(13 - k);
				kp6 = ~pads[i].fire2;
			end
			if (!sel.p8[i]) begin
				dnib = ~{pads[i].up, pads[i].right, pads[i].down, pads[i].left};
				dp6  = ~pads[i].fire1;
			end
			res.data[i] = knib & dnib;
			res.p6[i]   = kp6 & dp6;
		end
		return res;
	endfunction

	function automatic logic [18:0] mirror_ref(input logic [14:0] a);
		if (m_ext || (ram_size_i == cv_pkg::RAM_SGM && !m_sg))
			return 19'(a);
		else if (ram_size_i == cv_pkg::RAM_1K)
			return 19'(a[9:0]);
		else
			return 19'(a[12:0]);
	endfunction

	// ------------------------------
	// Stimulus tasks
	// ------------------------------
	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(negedge clk_sys);
		key_code_i    = code;
		key_pressed_i = pressed;
		key_strobe_i  = ~key_strobe_i;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_lines(input string what);
		check(what, 32'(ctrl_o), 32'(expect_lines(joys_i, joy_swap_i, kbd_m, ctrl_sel_i)));
	endtask

	task automatic dl_write(input logic [7:0] idx, input logic [24:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		dl_wr_i    = 1'b1;
		dl_index_i = idx;
		dl_addr_i  = a;
		dl_data_i  = d;
		if (a == 25'd0) begin
			m_ext = 1'b0;
			m_sg  = (idx == 8'd2);
		end else if (a >= 25'h2000 && a < 25'h4000 && m_sg)
			m_ext = (a == 25'h2000 || m_ext) && d == 8'hFF;
		m_pages = a[19:14];
		shadow[CART_AREA + 19'(a[17:0])] = d;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
	endtask

	task automatic cpu_access(input logic we, input logic [14:0] a, input logic [7:0] d);
		logic [18:0] m;
		m = mirror_ref(a);
		@(negedge clk_sys);
		cpu_req_i = '{req: 1'b1, we: we, addr: 19'(a), wdata: d};
		@(posedge clk_sys);
		while (dl_wr_i)
			@(posedge clk_sys);
		if (we)
			shadow[m] = d;
		else
			exp_cpu.push_back(shadow[m]);
		@(negedge clk_sys);
		cpu_req_i = '0;
	endtask

	task automatic cart_read(input logic [17:0] a);
		@(negedge clk_sys);
		cart_req_i = '{req: 1'b1, we: 1'b0, addr: 19'(a), wdata: 8'h00};
		@(posedge clk_sys);
		while (dl_wr_i || cpu_req_i.req)
			@(posedge clk_sys);
		exp_cart.push_back(shadow[CART_AREA + 19'(a)]);
		@(negedge clk_sys);
		cart_req_i = '0;
	endtask

	task automatic wait_idle();
		while (exp_cpu.size() != 0 || exp_cart.size() != 0)
			@(negedge clk_sys);
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		logic [14:0] waddr [10];
		arst_n_i = 1'b0;
		key_code_i = '0;
		key_strobe_i = 1'b0;
		key_pressed_i = 1'b0;
		joys_i = 6'h3F;
		joy_swap_i = 1'b0;
		ctrl_sel_i = '1;
		dl_active_i = 1'b0;
		dl_wr_i = 1'b0;
		dl_index_i = '0;
		dl_addr_i = '0;
		dl_data_i = '0;
		reset_req_i = 1'b0;
		ram_size_i = cv_pkg::RAM_8K;
		cpu_req_i = '0;
		cart_req_i = '0;
		sram_rdata_i = '0;
		kbd_m = '0;
		for (int a = 0; a < 524288; a++) begin
			sram_mem[a] = fill_byte(19'(a));
			shadow[a]   = fill_byte(19'(a));
		end
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n_i = 1'b1;
		check("console reset idle", 32'(console_reset_o), 0);

		// Keypad encoding
		ctrl_sel_i = '{p5: 2'b00, p8: 2'b11};
		send_key(8'h2E, 1'b1);
		kbd_m.digit5 = 1'b1;
		check_lines("key 5");
		send_key(8'h1E, 1'b1);
		kbd_m.digit2 = 1'b1;
		check_lines("key 2 over 5");
		send_key(8'h2E, 1'b0);
		send_key(8'h1E, 1'b0);
		kbd_m = '0;
		send_key(8'h7C, 1'b1);
		kbd_m.star = 1'b1;
		check_lines("key star");
		send_key(8'h7C, 1'b0);
		send_key(8'h12, 1'b1);
		send_key(8'h26, 1'b1);
		kbd_m = '0;
		kbd_m.number = 1'b1;
		check_lines("shift 3");
		send_key(8'h26, 1'b0);
		send_key(8'h12, 1'b0);
		kbd_m = '0;
		check_lines("no key");
		end_test("keypad encoding");

		// Joystick mode and swap
		ctrl_sel_i = '{p5: 2'b11, p8: 2'b00};
		joys_i = 6'b101110;                   // Up and fire1
		send_key(8'h74, 1'b1);
		send_key(8'h22, 1'b1);
		kbd_m.right = 1'b1;
		kbd_m.fire2 = 1'b1;
		check_lines("joystick");
		joy_swap_i = 1'b1;
		@(negedge clk_sys);
		check_lines("joystick swap");
		ctrl_sel_i = '0;
		@(negedge clk_sys);
		check_lines("both selects");
		joy_swap_i = 1'b0;
		@(negedge clk_sys);
		check_lines("both selects no swap");
		send_key(8'h74, 1'b0);
		send_key(8'h22, 1'b0);
		kbd_m = '0;
		joys_i = 6'h3F;
		ctrl_sel_i = '1;
		end_test("joystick mode");

		// Cartridge flags
		dl_active_i = 1'b1;
		dl_write(8'd2, 25'h0, 8'h00);
		check("sg1000", 32'(sg1000_o), 1);
		for (int i = 0; i < 16; i++)
			dl_write(8'd2, 25'h2000 + 25'(i), 8'hFF);
		check("extram set", 32'(extram_o), 1);
		dl_write(8'd2, 25'h2010, 8'h12);
		check("extram cleared", 32'(extram_o), 0);
		dl_write(8'd2, 25'h1C000, 8'h77);
		dl_active_i = 1'b0;
		check("cart pages", 32'(cart_pages_o), 32'(m_pages));
		check("model byte", 32'(sram_mem[CART_AREA + 19'h1C000]), 32'h77);
		cart_read(18'h0);
		cart_read(18'h2005);
		cart_read(18'h2010);
		cart_read(18'h1C000);
		wait_idle();
		end_test("cartridge flags");

		// RAM mirroring over flag and size combinations
		for (int cfg = 0; cfg < 3; cfg++) begin
			dl_active_i = 1'b1;
			dl_write((cfg == 0) ? 8'd0 : 8'd2, 25'h0, 8'h00);
			if (cfg == 2)
				dl_write(8'd2, 25'h2000, 8'hFF);
			dl_active_i = 1'b0;
			check("sg1000 flag", 32'(sg1000_o), 32'(m_sg));
			check("extram flag", 32'(extram_o), 32'(m_ext));
			for (int sz = 0; sz < 3; sz++) begin
				ram_size_i = cv_pkg::ram_size_e'(sz);
				for (int i = 0; i < 10; i++) begin
					rng = xorshift(rng);
					waddr[i] = rng[14:0];
					cpu_access(1'b1, waddr[i], rng[22:15]);
				end
				for (int i = 0; i < 10; i++) begin
					rng = xorshift(rng);
					cpu_access(1'b0, (i % 2 == 0) ? waddr[i] : rng[14:0], 8'h00);
				end
				wait_idle();
			end
		end
		end_test("ram mirroring");

		// Contention between all three peers
		cpu_seen  = 0;
		cart_seen = 0;
		rng = xorshift(rng);
		@(negedge clk_sys);
		dl_wr_i    = 1'b1;
		dl_index_i = 8'd0;
		dl_addr_i  = 25'h5A5A;
		dl_data_i  = 8'hC3;
		cpu_req_i  = '{req: 1'b1, we: 1'b0, addr: 19'(rng[14:0]), wdata: 8'h00};
		cart_req_i = '{req: 1'b1, we: 1'b0, addr: 19'h5A5A, wdata: 8'h00};
		@(posedge clk_sys);
		shadow[CART_AREA + 19'h5A5A] = 8'hC3;
		m_pages = 6'd1;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		@(posedge clk_sys);
		exp_cpu.push_back(shadow[mirror_ref(rng[14:0])]);
		@(negedge clk_sys);
		cpu_req_i = '0;
		@(posedge clk_sys);
		exp_cart.push_back(shadow[CART_AREA + 19'h5A5A]);
		@(negedge clk_sys);
		cart_req_i = '0;
		wait_idle();
		check("cpu before cart", 32'(cpu_seen != 0 && cpu_seen < cart_seen), 1);
		end_test("contention");

		// Console reset sources
		repeat (3) @(negedge clk_sys);
		check("reset low", 32'(console_reset_o), 0);
		send_key(8'h14, 1'b1);
		send_key(8'h11, 1'b1);
		send_key(8'h71, 1'b1);
		check("reset chord", 32'(console_reset_o), 1);
		send_key(8'h14, 1'b0);
		send_key(8'h11, 1'b0);
		send_key(8'h71, 1'b0);
		check("reset chord released", 32'(console_reset_o), 0);
		ram_size_i = cv_pkg::RAM_1K;
		repeat (2) @(negedge clk_sys);
		check("reset size change", 32'(console_reset_o), 1);
		@(negedge clk_sys);
		check("reset size settled", 32'(console_reset_o), 0);
		reset_req_i = 1'b1;
		@(negedge clk_sys);
		check("reset request", 32'(console_reset_o), 1);
		reset_req_i = 1'b0;
		dl_active_i = 1'b1;
		@(negedge clk_sys);
		check("reset download", 32'(console_reset_o), 1);
		dl_active_i = 1'b0;
		@(negedge clk_sys);
		check("reset released", 32'(console_reset_o), 0);
		end_test("console reset");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_cv_io_assertions.sv */
// Concurrent protocol checks on the shared SRAM arbiter
`default_nettype none

module tb_cv_io_assertions (
	input wire                    clk_sys,
	input wire                    arst_n_i,
	input wire cv_pkg::mem_req_t  wr_req_i,
	input wire cv_pkg::mem_req_t  cpu_req_i,
	input wire cv_pkg::mem_req_t  cart_req_i,
	input wire cv_pkg::sram_bus_t sram_o,
	input wire                    cpu_rvalid_o,
	input wire                    cart_rvalid_o
);
	timeunit 1ns;
	timeprecision 1ns;

	logic cpu_rd_grant;
	logic cart_rd_grant;

	// Read region on the bus tells which peer was served
	assign cpu_rd_grant  = sram_o.en & ~sram_o.we & ~sram_o.addr[18];
	assign cart_rd_grant = sram_o.en & ~sram_o.we & sram_o.addr[18];

	one_rvalid: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		$past(sram_o.en && !sram_o.we) |-> $onehot({cpu_rvalid_o, cart_rvalid_o}))
		else $error("Read not returned to exactly one peer");

	cpu_rvalid_granted: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		cpu_rvalid_o |-> $past(cpu_rd_grant)) else $error("CPU rvalid without grant");

	cart_rvalid_granted: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		cart_rvalid_o |-> $past(cart_rd_grant)) else $error("Cart rvalid without grant");

	cpu_req_held: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		(cpu_req_i.req && wr_req_i.req) |=> cpu_req_i.req) else $error("CPU request dropped");

	cart_req_held: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		(cart_req_i.req && (wr_req_i.req || cpu_req_i.req)) |=> cart_req_i.req)
		else $error("Cart request dropped");

endmodule

`default_nettype wire

/* hdl/cv_io_top.sv */
// Input and memory glue around the ColecoVision console core
`default_nettype none

module cv_io_top #(
	parameter int CART_AW = 18,
	parameter int CPU_AW  = 15
) (
	input  wire                       clk_sys,
	input  wire                       arst_n_i,
	// Keyboard events
	input  wire  [7:0]                key_code_i,
	input  wire                       key_strobe_i,
	input  wire                       key_pressed_i,
	// Controller ports
	input  wire  [5:0]                joys_i,
	input  wire                       joy_swap_i,
	input  wire  cv_pkg::ctrl_sel_t   ctrl_sel_i,
	output wire  cv_pkg::ctrl_lines_t ctrl_o,
	// Download bus
	input  wire                       dl_active_i,
	input  wire                       dl_wr_i,
	input  wire  [7:0]                dl_index_i,
	input  wire  [24:0]               dl_addr_i,
	input  wire  [7:0]                dl_data_i,
	// Console side
	input  wire                       reset_req_i,
	input  wire  cv_pkg::ram_size_e   ram_size_i,
	output wire                       console_reset_o,
	output wire                       sg1000_o,
	output wire                       extram_o,
	output wire  [5:0]                cart_pages_o,
	input  wire  cv_pkg::mem_req_t    cpu_req_i,
	input  wire  cv_pkg::mem_req_t    cart_req_i,
	output wire  [7:0]                cpu_rdata_o,
	output wire                       cpu_rvalid_o,
	output wire  [7:0]                cart_rdata_o,
	output wire                       cart_rvalid_o,
	// External SRAM
	output wire  cv_pkg::sram_bus_t   sram_o,
	input  wire  [7:0]                sram_rdata_i
);

	wire cv_pkg::pad_t     kbd_pad;
	wire                   kbd_reset;
	wire cv_pkg::mem_req_t wr_req;

	key_matrix u_key_matrix (
		.clk_sys       (clk_sys),
		.arst_n_i      (arst_n_i),
		.key_code_i    (key_code_i),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.kbd_pad_o     (kbd_pad),
		.kbd_reset_o   (kbd_reset)
	);

	ctrl_port_mux u_ctrl_port_mux (
		.joys_i        (joys_i),
		.joy_swap_i    (joy_swap_i),
		.kbd_pad_i     (kbd_pad),
		.ctrl_sel_i    (ctrl_sel_i),
		.ctrl_o        (ctrl_o)
	);

	cart_loader #(.CART_AW(CART_AW)) u_cart_loader (
		.clk_sys       (clk_sys),
		.arst_n_i      (arst_n_i),
		.dl_wr_i       (dl_wr_i),
		.dl_index_i    (dl_index_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.wr_req_o      (wr_req),
		.sg1000_o      (sg1000_o),
		.extram_o      (extram_o),
		.cart_pages_o  (cart_pages_o)
	);

	console_reset u_console_reset (
		.clk_sys         (clk_sys),
		.arst_n_i        (arst_n_i),
		.reset_req_i     (reset_req_i),
		.ram_size_i      (ram_size_i),
		.kbd_reset_i     (kbd_reset),
		.dl_active_i     (dl_active_i),
		.console_reset_o (console_reset_o)
	);

	sram_arbiter #(.CART_AW(CART_AW), .CPU_AW(CPU_AW)) u_sram_arbiter (
		.clk_sys       (clk_sys),
		.arst_n_i      (arst_n_i),
		.wr_req_i      (wr_req),
		.cpu_req_i     (cpu_req_i),
		.cart_req_i    (cart_req_i),
		.ram_size_i    (ram_size_i),
		.sg1000_i      (sg1000_o),
		.extram_i      (extram_o),
		.sram_o        (sram_o),
		.sram_rdata_i  (sram_rdata_i),
		.cpu_rdata_o   (cpu_rdata_o),
		.cpu_rvalid_o  (cpu_rvalid_o),
		.cart_rdata_o  (cart_rdata_o),
		.cart_rvalid_o (cart_rvalid_o)
	);

endmodule

`default_nettype wire

/* hdl/sram_arbiter.sv */
// Shared SRAM arbiter for download writer, CPU RAM port and cartridge reads
`default_nettype none

module sram_arbiter #(
	parameter int CART_AW = 18,
	parameter int CPU_AW  = 15
) (
	input  wire                     clk_sys,
	input  wire                     arst_n_i,
	input  wire  cv_pkg::mem_req_t  wr_req_i,
	input  wire  cv_pkg::mem_req_t  cpu_req_i,
	input  wire  cv_pkg::mem_req_t  cart_req_i,
	input  wire  cv_pkg::ram_size_e ram_size_i,
	input  wire                     sg1000_i,
	input  wire                     extram_i,
	output cv_pkg::sram_bus_t       sram_o,
	input  wire  [7:0]              sram_rdata_i,
	output logic [7:0]              cpu_rdata_o,
	output logic                    cpu_rvalid_o,
	output logic [7:0]              cart_rdata_o,
	output logic                    cart_rvalid_o
);

	cv_pkg::owner_e owner;
	cv_pkg::owner_e owner_q;
	logic           rd_q;
	logic [18:0]    cpu_addr;
	logic [18:0]    cart_addr;

	// ------------------------------
	// Address mapping
	// ------------------------------
	always_comb begin
		if (extram_i)
			cpu_addr = 19'(cpu_req_i.addr[CPU_AW-1:0]);
		else begin
			case (ram_size_i)
				cv_pkg::RAM_1K:  cpu_addr = 19'(cpu_req_i.addr[9:0]);
				cv_pkg::RAM_8K:  cpu_addr = 19'(cpu_req_i.addr[12:0]);
				cv_pkg::RAM_SGM: cpu_addr = sg1000_i ? 19'(cpu_req_i.addr[12:0])
				                                     : 19'(cpu_req_i.addr[CPU_AW-1:0]);
				default:         cpu_addr = 19'(cpu_req_i.addr[CPU_AW-1:0]);
			endcase
		end
	end

	assign cart_addr = cv_pkg::CART_BASE + 19'(cart_req_i.addr[CART_AW-1:0]);

	// ------------------------------
	// Fixed priority grant
	// ------------------------------
	always_comb begin
		owner  = cv_pkg::OWN_NONE;
		sram_o = '0;
		if (wr_req_i.req) begin
			owner        = cv_pkg::OWN_LOADER;
			sram_o.en    = 1'b1;
			sram_o.we    = wr_req_i.we;
			sram_o.addr  = wr_req_i.addr;
			sram_o.wdata = wr_req_i.wdata;
		end else if (cpu_req_i.req) begin
			owner        = cv_pkg::OWN_CPU;
			sram_o.en    = 1'b1;
			sram_o.we    = cpu_req_i.we;
			sram_o.addr  = cpu_addr;
			sram_o.wdata = cpu_req_i.wdata;
		end else if (cart_req_i.req) begin
			owner        = cv_pkg::OWN_CART;
			sram_o.en    = 1'b1;          // Cartridge port only reads
			sram_o.addr  = cart_addr;
		end
	end

	// Remember who reads so the data goes back to them
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			owner_q <= cv_pkg::OWN_NONE;
			rd_q    <= 1'b0;
		end else begin
			owner_q <= owner;
			rd_q    <= sram_o.en & ~sram_o.we;
		end
	end

	assign cpu_rvalid_o  = rd_q && (owner_q == cv_pkg::OWN_CPU);
	assign cart_rvalid_o = rd_q && (owner_q == cv_pkg::OWN_CART);
	assign cpu_rdata_o   = cpu_rvalid_o ? sram_rdata_i : 8'h00;
	assign cart_rdata_o  = cart_rvalid_o ? sram_rdata_i : 8'h00;

endmodule

`default_nettype wire

/* hdl/console_reset.sv */
// Console soft reset generator combining request, RAM size change, chord and download
`default_nettype none

module console_reset (
	input  wire                     clk_sys,
	input  wire                     arst_n_i,
	input  wire                     reset_req_i,
	input  wire  cv_pkg::ram_size_e ram_size_i,
	input  wire                     kbd_reset_i,
	input  wire                     dl_active_i,
	output logic                    console_reset_o
);

	cv_pkg::ram_size_e size_q;
	cv_pkg::ram_size_e size_qq;

	// RAM size history for change detection
	always_ff @(posedge clk_sys) begin
		size_q  <= ram_size_i;
		size_qq <= size_q;
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i)
			console_reset_o <= 1'b0;
		else
			console_reset_o <= reset_req_i | (size_q != size_qq) | kbd_reset_i | dl_active_i;
	end

endmodule

`default_nettype wire

/* hdl/cart_loader.sv */
// Cartridge download tracker for SG-1000 flag, expansion RAM and page count
`default_nettype none

module cart_loader #(
	parameter int CART_AW = 18
) (
	input  wire              clk_sys,
	input  wire              arst_n_i,
	input  wire              dl_wr_i,
	input  wire  [7:0]       dl_index_i,
	input  wire  [24:0]      dl_addr_i,
	input  wire  [7:0]       dl_data_i,
	output cv_pkg::mem_req_t wr_req_o,
	output logic             sg1000_o,
	output logic             extram_o,
	output logic [5:0]       cart_pages_o
);

	logic page_2000;
	logic page_start;

	assign page_2000  = (dl_addr_i[24:13] == 12'd1);    // 0x2000..0x3FFF
	assign page_start = (dl_addr_i[12:0] == 13'd0);

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sg1000_o     <= 1'b0;
			extram_o     <= 1'b0;
			cart_pages_o <= '0;
		end else if (dl_wr_i) begin
			if (dl_addr_i == 25'd0) begin
				extram_o <= 1'b0;
				sg1000_o <= (dl_index_i == 8'd2);
			end
			// All-FF page means RAM is fitted there
			if (page_2000 && sg1000_o)
				extram_o <= (page_start | extram_o) & (&dl_data_i);
			cart_pages_o <= dl_addr_i[19:14];
		end
	end

	// Straight into the cartridge area, no back-pressure
	always_comb begin
		wr_req_o.req   = dl_wr_i;
		wr_req_o.we    = 1'b1;
		wr_req_o.addr  = cv_pkg::CART_BASE + 19'(dl_addr_i[CART_AW-1:0]);
		wr_req_o.wdata = dl_data_i;
	end

endmodule

`default_nettype wire

/* hdl/ctrl_port_mux.sv */
// Controller port multiplexer building both console ports from joystick and keyboard pads
`default_nettype none

module ctrl_port_mux (
	input  wire  [5:0]              joys_i,
	input  wire                     joy_swap_i,
	input  wire  cv_pkg::pad_t      kbd_pad_i,
	input  wire  cv_pkg::ctrl_sel_t ctrl_sel_i,
	output cv_pkg::ctrl_lines_t     ctrl_o
);

	localparam cv_pkg::pad_t DIR_MASK = '{up: 1'b1, down: 1'b1, left: 1'b1, right: 1'b1,
		fire1: 1'b1, fire2: 1'b1, default: 1'b0};

	cv_pkg::pad_t phys_pad;
	cv_pkg::pad_t kbd_dir;
	cv_pkg::pad_t kbd_keys;
	cv_pkg::pad_t port_pad [2];

	// First pressed key in priority order
	function automatic cv_pkg::cv_key_e encode_key(input cv_pkg::pad_t pad);
		if (pad.digit0)      return cv_pkg::KEY_0;
		else if (pad.digit1) return cv_pkg::KEY_1;
		else if (pad.digit2) return cv_pkg::KEY_2;
		else if (pad.digit3) return cv_pkg::KEY_3;
		else if (pad.digit4) return cv_pkg::KEY_4;
		else if (pad.digit5) return cv_pkg::KEY_5;
		else if (pad.digit6) return cv_pkg::KEY_6;
		else if (pad.digit7) return cv_pkg::KEY_7;
		else if (pad.digit8) return cv_pkg::KEY_8;
		else if (pad.digit9) return cv_pkg::KEY_9;
		else if (pad.star)   return cv_pkg::KEY_STAR;
		else if (pad.number) return cv_pkg::KEY_NUM;
		else if (pad.purple) return cv_pkg::KEY_PT;
		else if (pad.blue)   return cv_pkg::KEY_BT;
		else                 return cv_pkg::KEY_NONE;
	endfunction

	// ------------------------------
	// Pad selection
	// ------------------------------
	always_comb begin
		phys_pad       = '0;
		phys_pad.up    = ~joys_i[0];          // Joystick is active low
		phys_pad.down  = ~joys_i[1];
		phys_pad.left  = ~joys_i[2];
		phys_pad.right = ~joys_i[3];
		phys_pad.fire1 = ~joys_i[4];
		phys_pad.fire2 = ~joys_i[5];
		kbd_dir        = kbd_pad_i & DIR_MASK;
		kbd_keys       = kbd_pad_i & ~DIR_MASK;
		port_pad[0]    = (joy_swap_i ? kbd_dir : phys_pad) | kbd_keys;
		port_pad[1]    = (joy_swap_i ? phys_pad : kbd_dir) | kbd_keys;
	end

	// ------------------------------
	// Line encoding per port
	// ------------------------------
	always_comb begin
		logic [3:0] key_nib;
		logic [3:0] dir_nib;
		logic       key_p6;
		logic       dir_p6;

		ctrl_o = '1;
		for (int i = 0; i < 2; i++) begin
			key_nib = 4'b1111;
			dir_nib = 4'b1111;
			key_p6  = 1'b1;
			dir_p6  = 1'b1;
			if (!ctrl_sel_i.p5[i]) begin       // Keypad mode
				key_nib = encode_key(port_pad[i]);
				key_p6  = ~port_pad[i].fire2;
			end
			if (!ctrl_sel_i.p8[i]) begin       // Joystick mode
				dir_nib = ~{port_pad[i].up, port_pad[i].right,
					port_pad[i].down, port_pad[i].left};
				dir_p6  = ~port_pad[i].fire1;
			end
			ctrl_o.data[i] = key_nib & dir_nib;
			ctrl_o.p6[i]   = key_p6 & dir_p6;
		end
	end

endmodule

`default_nettype wire

/* hdl/key_matrix.sv */
// Keyboard decoder that turns PS/2 scancode events into held keypad buttons
`default_nettype none

module key_matrix (
	input  wire              clk_sys,
	input  wire              arst_n_i,
	input  wire  [7:0]       key_code_i,
	input  wire              key_strobe_i,
	input  wire              key_pressed_i,
	output cv_pkg::pad_t     kbd_pad_o,
	output logic             kbd_reset_o
);

	logic         strobe_q;
	logic         strobe_qq;
	logic [7:0]   code_q;
	logic         pressed_q;
	cv_pkg::pad_t btn_q;                  // Raw held keys
	logic         shift_q;
	logic         minus_q;
	logic         ctrl_q;
	logic         alt_q;
	logic         del_q;

	// ------------------------------
	// Event sampling
	// ------------------------------
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			strobe_q  <= 1'b0;
			strobe_qq <= 1'b0;
		end else begin
			strobe_q  <= key_strobe_i;
			strobe_qq <= strobe_q;          // Delayed copy for toggle detect
		end
	end

	always_ff @(posedge clk_sys) begin
		code_q    <= key_code_i;
		pressed_q <= key_pressed_i;
	end

	// ------------------------------
	// Held key state
	// ------------------------------
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			btn_q   <= '0;
			shift_q <= 1'b0;
			minus_q <= 1'b0;
			ctrl_q  <= 1'b0;
			alt_q   <= 1'b0;
			del_q   <= 1'b0;
		end else if (strobe_q != strobe_qq) begin
			case (code_q)
				8'h16: btn_q.digit1 <= pressed_q;
				8'h1E: btn_q.digit2 <= pressed_q;
				8'h26: btn_q.digit3 <= pressed_q;
				8'h25: btn_q.digit4 <= pressed_q;
				8'h2E: btn_q.digit5 <= pressed_q;
				8'h36: btn_q.digit6 <= pressed_q;
				8'h3D: btn_q.digit7 <= pressed_q;
				8'h3E: btn_q.digit8 <= pressed_q;
				8'h46: btn_q.digit9 <= pressed_q;
				8'h45: btn_q.digit0 <= pressed_q;
				8'h7C: btn_q.star   <= pressed_q;    // Keypad *
				8'h7B: minus_q      <= pressed_q;    // Keypad -
				8'h59: shift_q      <= pressed_q;    // Right shift
				8'h12: shift_q      <= pressed_q;    // Left shift
				8'h75: btn_q.up     <= pressed_q;
				8'h72: btn_q.down   <= pressed_q;
				8'h6B: btn_q.left   <= pressed_q;
				8'h74: btn_q.right  <= pressed_q;
				8'h1A: btn_q.fire1  <= pressed_q;    // Z
				8'h22: btn_q.fire2  <= pressed_q;    // X
				8'h71: del_q        <= pressed_q;
				8'h11: alt_q        <= pressed_q;
				8'h14: ctrl_q       <= pressed_q;
				default: ;
			endcase
		end
	end

	// Shifted 8 and 3 become star and number
	always_comb begin
		kbd_pad_o        = btn_q;
		kbd_pad_o.digit3 = btn_q.digit3 & ~shift_q;
		kbd_pad_o.digit8 = btn_q.digit8 & ~shift_q;
		kbd_pad_o.star   = btn_q.star | (shift_q & btn_q.digit8);
		kbd_pad_o.number = minus_q | (shift_q & btn_q.digit3);
	end

	assign kbd_reset_o = ctrl_q & alt_q & del_q;   // Ctrl+alt+del chord

endmodule

`default_nettype wire

/* hdl/cv_pkg.sv */
// Shared types and keypad codes for the ColecoVision input and memory glue
`default_nettype none

package cv_pkg;

	// ------------------------------
	// Enumerations
	// ------------------------------
	typedef enum logic [1:0] {
		RAM_1K  = 2'd0,
		RAM_8K  = 2'd1,
		RAM_SGM = 2'd2
	} ram_size_e;

	typedef enum logic [3:0] {
		KEY_0    = 4'b0011,
		KEY_1    = 4'b1110,
		KEY_2    = 4'b1101,
		KEY_3    = 4'b0110,
		KEY_4    = 4'b0001,
		KEY_5    = 4'b1001,
		KEY_6    = 4'b0111,
		KEY_7    = 4'b1100,
		KEY_8    = 4'b1000,
		KEY_9    = 4'b1011,
		KEY_STAR = 4'b1010,
		KEY_NUM  = 4'b0101,
		KEY_PT   = 4'b0100,       // Purple trigger
		KEY_BT   = 4'b0010,       // Blue trigger
		KEY_NONE = 4'b1111
	} cv_key_e;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_LOADER,
		OWN_CPU,
		OWN_CART
	} owner_e;

	// ------------------------------
	// Bundles
	// ------------------------------
	// Field order follows keypad priority with the highest first
	typedef struct packed {
		logic digit0;
		logic digit1;
		logic digit2;
		logic digit3;
		logic digit4;
		logic digit5;
		logic digit6;
		logic digit7;
		logic digit8;
		logic digit9;
		logic star;
		logic number;
		logic purple;
		logic blue;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
	} pad_t;

	typedef struct packed {
		logic [1:0] p5;           // Keypad select, one per port
		logic [1:0] p8;           // Joystick select, one per port
	} ctrl_sel_t;

	typedef struct packed {
		logic [1:0][3:0] data;    // p1..p4, p1 in the MSB
		logic [1:0]      p6;
	} ctrl_lines_t;

	typedef struct packed {
		logic        req;
		logic        we;
		logic [18:0] addr;
		logic [7:0]  wdata;
	} mem_req_t;

	typedef struct packed {
		logic        en;
		logic        we;
		logic [18:0] addr;
		logic [7:0]  wdata;
	} sram_bus_t;

	localparam logic [18:0] CART_BASE = 19'h40000;   // Upper half of the SRAM

endpackage

`default_nettype wire
